//--- logic/axil_fifo_pkg.sv
// constants, state/response types and window decode for the axi-lite fifo bridge
// fifo words are fixed at 32 bits; the host always writes full words
package axil_fifo_pkg;

  localparam int NUM_SLOTS   = 2;
  localparam int FIFO_ELS    = 8;
  localparam int COUNT_W     = 4;                  // holds 0..FIFO_ELS
  localparam int PTR_W       = $clog2(FIFO_ELS);
  localparam logic [31:0] BASE_ADDR = 32'h0001_0000;
  localparam int SLOT_ADDR_W = 12;                 // 4 KiB per window
  localparam int RLR_WORDS   = 4;                  // burst behind RLR

  // ----------------------------------------------------------------------
  // register offsets inside a slot window
  // ----------------------------------------------------------------------
  localparam logic [SLOT_ADDR_W-1:0] OFS_ISR  = 'h000;  // interrupt status
  localparam logic [SLOT_ADDR_W-1:0] OFS_TDFV = 'h00C;  // tx vacancy
  localparam logic [SLOT_ADDR_W-1:0] OFS_TDR  = 'h010;  // tx data
  localparam logic [SLOT_ADDR_W-1:0] OFS_RDFO = 'h01C;  // rx occupancy
  localparam logic [SLOT_ADDR_W-1:0] OFS_RDR  = 'h020;  // rx data
  localparam logic [SLOT_ADDR_W-1:0] OFS_RLR  = 'h024;  // rx length

  localparam logic [31:0] DEFAULT_RDATA   = 32'hBEEF_DEAD;
  localparam int          ISR_TX_DONE_BIT = 27;

  typedef enum logic [1:0] {
    WR_IDLE = 2'd0,
    WR_ADDR = 2'd1,
    WR_DATA = 2'd2,
    WR_RESP = 2'd3
  } wr_state_e;

  typedef enum logic [1:0] {
    RD_IDLE = 2'd0,
    RD_ADDR = 2'd1,
    RD_DATA = 2'd2
  } rd_state_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_DECERR = 2'd3
  } resp_e;

  // 0..NUM_SLOTS-1 are slots, NUM_SLOTS is the rom, anything else invalid
  function automatic logic [31:0] window_index(input logic [31:0] addr);
    logic [31:0] rel;
    rel = addr - BASE_ADDR;
    if (addr < BASE_ADDR) begin
      return '1;  // below base, never a valid window
    end
    return rel >> SLOT_ADDR_W;
  endfunction

endpackage

//--- logic/fifo_small.sv
// register-array fifo, 32-bit words, depth from the package
// data_o is the head word, valid the cycle after the first enqueue
module fifo_small (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              v_i,
  output logic                              ready_o,
  input  logic [31:0]                       data_i,
  output logic                              v_o,
  output logic [31:0]                       data_o,
  input  logic                              yumi_i,
  output logic [axil_fifo_pkg::COUNT_W-1:0] count_o
);

  logic [31:0]                       mem_r [axil_fifo_pkg::FIFO_ELS];
  logic [axil_fifo_pkg::PTR_W-1:0]   wr_ptr_r;
  logic [axil_fifo_pkg::PTR_W-1:0]   rd_ptr_r;
  logic [axil_fifo_pkg::COUNT_W-1:0] count_r;
  logic                              enq;
  logic                              deq;

  assign ready_o = (count_r != axil_fifo_pkg::COUNT_W'(axil_fifo_pkg::FIFO_ELS));
  assign v_o     = (count_r != '0);
  assign enq     = v_i & ready_o;
  assign deq     = yumi_i & v_o;  // a yumi on an empty fifo is ignored
  assign data_o  = mem_r[rd_ptr_r];
  assign count_o = count_r;

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  // pointers wrap at FIFO_ELS, so depth need not be a power of two
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
    end else begin
      if (enq) begin
        wr_ptr_r <= (wr_ptr_r == axil_fifo_pkg::PTR_W'(axil_fifo_pkg::FIFO_ELS - 1))
                    ? '0 : wr_ptr_r + 1'b1;
      end
      if (deq) begin
        rd_ptr_r <= (rd_ptr_r == axil_fifo_pkg::PTR_W'(axil_fifo_pkg::FIFO_ELS - 1))
                    ? '0 : rd_ptr_r + 1'b1;
      end
    end
  end

  // occupancy, unchanged on simultaneous enq and deq
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
    end else if (enq && !deq) begin
      count_r <= count_r + 1'b1;
    end else if (deq && !enq) begin
      count_r <= count_r - 1'b1;
    end
  end

endmodule

//--- logic/axil_write_ctrl.sv
// axi-lite write channel; address and data phases are taken one after the other
// a TDR write to a full fifo is dropped but still answers OKAY
module axil_write_ctrl (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  input  logic [31:0]                                awaddr_i,
  input  logic                                       awvalid_i,
  output logic                                       awready_o,
  input  logic [31:0]                                wdata_i,
  input  logic                                       wvalid_i,
  output logic                                       wready_o,
  output axil_fifo_pkg::resp_e                       bresp_o,
  output logic                                       bvalid_o,
  input  logic                                       bready_i,
  output logic [axil_fifo_pkg::NUM_SLOTS-1:0]        tx_v_o,
  output logic [31:0]                                tx_data_o,
  input  logic [axil_fifo_pkg::NUM_SLOTS-1:0]        tx_ready_i,
  output logic [axil_fifo_pkg::NUM_SLOTS-1:0][31:0]  isr_o
);

  axil_fifo_pkg::wr_state_e                 state_r;
  axil_fifo_pkg::wr_state_e                 state_n;
  logic [31:0]                              addr_r;
  logic [31:0]                              wdata_r;
  logic                                     commit_r;  // first resp cycle
  logic [31:0]                              win;
  logic [axil_fifo_pkg::SLOT_ADDR_W-1:0]    ofs;
  logic [axil_fifo_pkg::NUM_SLOTS-1:0][31:0] isr_r;

  // ----------------------------------------------------------------------
  // write fsm
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= axil_fifo_pkg::WR_IDLE;
    end else begin
      state_r <= state_n;
    end
  end

  always_comb begin
    state_n = state_r;
    case (state_r)
      axil_fifo_pkg::WR_IDLE: if (awvalid_i) state_n = axil_fifo_pkg::WR_ADDR;
      axil_fifo_pkg::WR_ADDR: state_n = axil_fifo_pkg::WR_DATA;  // one-cycle awready
      axil_fifo_pkg::WR_DATA: if (wvalid_i) state_n = axil_fifo_pkg::WR_RESP;
      axil_fifo_pkg::WR_RESP: if (bready_i) state_n = axil_fifo_pkg::WR_IDLE;
      default:                state_n = axil_fifo_pkg::WR_IDLE;
    endcase
  end

  assign awready_o = (state_r == axil_fifo_pkg::WR_ADDR);
  assign wready_o  = (state_r == axil_fifo_pkg::WR_DATA);
  assign bvalid_o  = (state_r == axil_fifo_pkg::WR_RESP);

  always_ff @(posedge clk_i) begin
    if (awvalid_i && awready_o) addr_r <= awaddr_i;
    if (wvalid_i && wready_o) wdata_r <= wdata_i;
  end

  // enqueue and isr update happen once, as bvalid rises
  always_ff @(posedge clk_i) begin
    if (reset_i) commit_r <= 1'b0;
    else commit_r <= wvalid_i & wready_o;
  end

  // ----------------------------------------------------------------------
  // decode, fifo push and status registers
  // ----------------------------------------------------------------------
  assign win       = axil_fifo_pkg::window_index(addr_r);
  assign ofs       = addr_r[axil_fifo_pkg::SLOT_ADDR_W-1:0];
  assign bresp_o   = (win < 32'(axil_fifo_pkg::NUM_SLOTS)) ? axil_fifo_pkg::RESP_OKAY
                                                            : axil_fifo_pkg::RESP_DECERR;
  assign tx_data_o = wdata_r;

  for (genvar i = 0; i < axil_fifo_pkg::NUM_SLOTS; i++) begin : g_slot
    logic hit;
    assign hit       = (win == 32'(i));
    assign tx_v_o[i] = commit_r & hit & (ofs == axil_fifo_pkg::OFS_TDR);

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        isr_r[i] <= '0;
      end else if (commit_r && hit && (ofs == axil_fifo_pkg::OFS_ISR)) begin
        isr_r[i] <= wdata_r;  // whole-word load, used to clear
      end else if (tx_v_o[i] && tx_ready_i[i]) begin
        isr_r[i][axil_fifo_pkg::ISR_TX_DONE_BIT] <= 1'b1;
      end
    end
  end

  assign isr_o = isr_r;

endmodule

//--- logic/axil_read_ctrl.sv
// axi-lite read channel with per-slot register mux and a rom pass-through window
// rdata/rresp are sampled once and held; an RDR read of an empty fifo pops nothing
module axil_read_ctrl (
  input  logic                                                    clk_i,
  input  logic                                                    reset_i,
  input  logic [31:0]                                             araddr_i,
  input  logic                                                    arvalid_i,
  output logic                                                    arready_o,
  output logic [31:0]                                             rdata_o,
  output axil_fifo_pkg::resp_e                                    rresp_o,
  output logic                                                    rvalid_o,
  input  logic                                                    rready_i,
  input  logic [axil_fifo_pkg::NUM_SLOTS-1:0][31:0]               isr_i,
  input  logic [axil_fifo_pkg::NUM_SLOTS-1:0][axil_fifo_pkg::COUNT_W-1:0] tx_count_i,
  input  logic [axil_fifo_pkg::NUM_SLOTS-1:0][axil_fifo_pkg::COUNT_W-1:0] rx_count_i,
  input  logic [axil_fifo_pkg::NUM_SLOTS-1:0]                     rx_valid_i,
  input  logic [axil_fifo_pkg::NUM_SLOTS-1:0][31:0]               rx_data_i,
  output logic [axil_fifo_pkg::NUM_SLOTS-1:0]                     rx_yumi_o,
  output logic [31:0]                                             rom_addr_o,
  input  logic [31:0]                                             rom_data_i
);

  axil_fifo_pkg::rd_state_e              state_r;
  axil_fifo_pkg::rd_state_e              state_n;
  logic [31:0]                           addr_r;
  logic [31:0]                           win;
  logic [axil_fifo_pkg::SLOT_ADDR_W-1:0] ofs;
  logic [31:0]                           rdata_n;
  logic [31:0]                           rdata_r;
  axil_fifo_pkg::resp_e                  rresp_n;
  axil_fifo_pkg::resp_e                  rresp_r;
  logic [axil_fifo_pkg::NUM_SLOTS-1:0]   pop_sel_n;
  logic [axil_fifo_pkg::NUM_SLOTS-1:0]   pop_sel_r;

  // ----------------------------------------------------------------------
  // read fsm
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= axil_fifo_pkg::RD_IDLE;
    end else begin
      state_r <= state_n;
    end
  end

  always_comb begin
    state_n = state_r;
    case (state_r)
      axil_fifo_pkg::RD_IDLE: if (arvalid_i) state_n = axil_fifo_pkg::RD_ADDR;
      axil_fifo_pkg::RD_ADDR: state_n = axil_fifo_pkg::RD_DATA;
      axil_fifo_pkg::RD_DATA: if (rready_i) state_n = axil_fifo_pkg::RD_IDLE;
      default:                state_n = axil_fifo_pkg::RD_IDLE;
    endcase
  end

  assign arready_o = (state_r == axil_fifo_pkg::RD_ADDR);
  assign rvalid_o  = (state_r == axil_fifo_pkg::RD_DATA);

  // araddr is held with arvalid, so take it early and decode during RD_ADDR
  always_ff @(posedge clk_i) begin
    if ((state_r == axil_fifo_pkg::RD_IDLE) && arvalid_i) begin
      addr_r <= araddr_i;
    end
  end

  assign win        = axil_fifo_pkg::window_index(addr_r);
  assign ofs        = addr_r[axil_fifo_pkg::SLOT_ADDR_W-1:0];
  assign rom_addr_o = addr_r;

  // ----------------------------------------------------------------------
  // register mux
  // ----------------------------------------------------------------------
  always_comb begin
    rdata_n   = '0;
    rresp_n   = axil_fifo_pkg::RESP_DECERR;
    pop_sel_n = '0;
    if (win == 32'(axil_fifo_pkg::NUM_SLOTS)) begin
      rdata_n = rom_data_i;  // rom window, full offset passed through
      rresp_n = axil_fifo_pkg::RESP_OKAY;
    end
    for (int i = 0; i < axil_fifo_pkg::NUM_SLOTS; i++) begin
      if (win == 32'(i)) begin
        rresp_n = axil_fifo_pkg::RESP_OKAY;
        case (ofs)
          axil_fifo_pkg::OFS_ISR:  rdata_n = isr_i[i];
          axil_fifo_pkg::OFS_TDFV: rdata_n = 32'(axil_fifo_pkg::FIFO_ELS) - 32'(tx_count_i[i]);
          axil_fifo_pkg::OFS_RDFO: rdata_n = 32'(rx_count_i[i]);
          axil_fifo_pkg::OFS_RDR: begin
            rdata_n      = rx_data_i[i];   // stale if empty
            pop_sel_n[i] = rx_valid_i[i];
          end
          axil_fifo_pkg::OFS_RLR:
            rdata_n = (rx_count_i[i] >= axil_fifo_pkg::COUNT_W'(axil_fifo_pkg::RLR_WORDS))
                      ? 32'(4 * axil_fifo_pkg::RLR_WORDS) : '0;  // length in bytes
          default: rdata_n = axil_fifo_pkg::DEFAULT_RDATA;
        endcase
      end
    end
  end

  // snapshot at the end of RD_ADDR, held through the whole rvalid stall
  always_ff @(posedge clk_i) begin
    if (state_r == axil_fifo_pkg::RD_ADDR) begin
      rdata_r <= rdata_n;
      rresp_r <= rresp_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pop_sel_r <= '0;
    end else if (state_r == axil_fifo_pkg::RD_ADDR) begin
      pop_sel_r <= pop_sel_n;
    end
  end

  assign rdata_o   = rdata_r;
  assign rresp_o   = rresp_r;
  // only this module pops, so a head seen at the snapshot is still there
  assign rx_yumi_o = pop_sel_r & {axil_fifo_pkg::NUM_SLOTS{rvalid_o & rready_i}};

endmodule

//--- logic/axil_fifo_bridge.sv
// axi-lite slave to NUM_SLOTS tx/rx fifo pairs, one 4 KiB window per slot
// the window after the last slot reads an external rom; no byte strobes
module axil_fifo_bridge (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  // axi-lite write
  input  logic [31:0]                                s_awaddr_i,
  input  logic                                       s_awvalid_i,
  output logic                                       s_awready_o,
  input  logic [31:0]                                s_wdata_i,
  input  logic                                       s_wvalid_i,
  output logic                                       s_wready_o,
  output axil_fifo_pkg::resp_e                       s_bresp_o,
  output logic                                       s_bvalid_o,
  input  logic                                       s_bready_i,
  // axi-lite read
  input  logic [31:0]                                s_araddr_i,
  input  logic                                       s_arvalid_i,
  output logic                                       s_arready_o,
  output logic [31:0]                                s_rdata_o,
  output axil_fifo_pkg::resp_e                       s_rresp_o,
  output logic                                       s_rvalid_o,
  input  logic                                       s_rready_i,
  // fabric side, tx drains out and rx fills in
  output logic [axil_fifo_pkg::NUM_SLOTS-1:0]        fifo_v_o,
  output logic [axil_fifo_pkg::NUM_SLOTS-1:0][31:0]  fifo_data_o,
  input  logic [axil_fifo_pkg::NUM_SLOTS-1:0]        fifo_rdy_i,
  input  logic [axil_fifo_pkg::NUM_SLOTS-1:0]        fifo_v_i,
  input  logic [axil_fifo_pkg::NUM_SLOTS-1:0][31:0]  fifo_data_i,
  output logic [axil_fifo_pkg::NUM_SLOTS-1:0]        fifo_rdy_o,
  // rom
  output logic [31:0]                                rom_addr_o,
  input  logic [31:0]                                rom_data_i
);

  logic [axil_fifo_pkg::NUM_SLOTS-1:0]                            tx_v;
  logic [31:0]                                                    tx_data;
  logic [axil_fifo_pkg::NUM_SLOTS-1:0]                            tx_ready;
  logic [axil_fifo_pkg::NUM_SLOTS-1:0][axil_fifo_pkg::COUNT_W-1:0] tx_count;
  logic [axil_fifo_pkg::NUM_SLOTS-1:0][31:0]                      isr;
  logic [axil_fifo_pkg::NUM_SLOTS-1:0]                            rx_yumi;
  logic [axil_fifo_pkg::NUM_SLOTS-1:0]                            rx_valid;
  logic [axil_fifo_pkg::NUM_SLOTS-1:0][31:0]                      rx_data;
  logic [axil_fifo_pkg::NUM_SLOTS-1:0][axil_fifo_pkg::COUNT_W-1:0] rx_count;

  axil_write_ctrl wr_ctrl (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .awaddr_i   (s_awaddr_i),
    .awvalid_i  (s_awvalid_i),
    .awready_o  (s_awready_o),
    .wdata_i    (s_wdata_i),
    .wvalid_i   (s_wvalid_i),
    .wready_o   (s_wready_o),
    .bresp_o    (s_bresp_o),
    .bvalid_o   (s_bvalid_o),
    .bready_i   (s_bready_i),
    .tx_v_o     (tx_v),
    .tx_data_o  (tx_data),
    .tx_ready_i (tx_ready),
    .isr_o      (isr)
  );

  axil_read_ctrl rd_ctrl (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .araddr_i   (s_araddr_i),
    .arvalid_i  (s_arvalid_i),
    .arready_o  (s_arready_o),
    .rdata_o    (s_rdata_o),
    .rresp_o    (s_rresp_o),
    .rvalid_o   (s_rvalid_o),
    .rready_i   (s_rready_i),
    .isr_i      (isr),
    .tx_count_i (tx_count),
    .rx_count_i (rx_count),
    .rx_valid_i (rx_valid),
    .rx_data_i  (rx_data),
    .rx_yumi_o  (rx_yumi),
    .rom_addr_o (rom_addr_o),
    .rom_data_i (rom_data_i)
  );

  // ----------------------------------------------------------------------
  // per-slot fifo pairs
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < axil_fifo_pkg::NUM_SLOTS; i++) begin : g_slot
    // fifo_rdy_i works as yumi, the fifo masks it while empty
    fifo_small tx_fifo (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .v_i     (tx_v[i]),
      .ready_o (tx_ready[i]),
      .data_i  (tx_data),
      .v_o     (fifo_v_o[i]),
      .data_o  (fifo_data_o[i]),
      .yumi_i  (fifo_rdy_i[i]),
      .count_o (tx_count[i])
    );

    fifo_small rx_fifo (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .v_i     (fifo_v_i[i]),
      .ready_o (fifo_rdy_o[i]),  // low only when full
      .data_i  (fifo_data_i[i]),
      .v_o     (rx_valid[i]),
      .data_o  (rx_data[i]),
      .yumi_i  (rx_yumi[i]),
      .count_o (rx_count[i])
    );
  end

endmodule

//--- bench/clock_gen.sv
// free-running 4 ns clock; reset high for the first 3 rising edges
module clock_gen (
  output logic clk_o,
  output logic reset_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (3) @(posedge clk_o);
    #1 reset_o = 1'b0;  // released like any other input
  end

endmodule

//--- bench/bridge_chk.sv
// handshake assertions bound into the bridge top level
module bridge_chk (
  input logic                                      clk_i,
  input logic                                      reset_i,
  input logic                                      s_awready_o,
  input logic                                      s_arready_o,
  input logic                                      s_bvalid_o,
  input logic                                      s_bready_i,
  input axil_fifo_pkg::resp_e                      s_bresp_o,
  input logic                                      s_rvalid_o,
  input logic                                      s_rready_i,
  input logic [31:0]                               s_rdata_o,
  input axil_fifo_pkg::resp_e                      s_rresp_o,
  input logic [axil_fifo_pkg::NUM_SLOTS-1:0]       fifo_v_o
);
  timeunit 1ns;
  timeprecision 100ps;

  aw_one_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    s_awready_o |=> !s_awready_o) else $error("awready high two cycles in a row");

  ar_one_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    s_arready_o |=> !s_arready_o) else $error("arready high two cycles in a row");

  // stalled response must hold
  b_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o))
    else $error("write response changed while stalled");

  r_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o) && $stable(s_rresp_o))
    else $error("read response changed while stalled");

  tx_quiet: assert property (@(posedge clk_i) reset_i |=> fifo_v_o == '0)
    else $error("fifo_v_o high right after reset");

endmodule

bind axil_fifo_bridge bridge_chk chk0 (
  .clk_i(clk_i), .reset_i(reset_i), .s_awready_o(s_awready_o), .s_arready_o(s_arready_o),
  .s_bvalid_o(s_bvalid_o), .s_bready_i(s_bready_i), .s_bresp_o(s_bresp_o),
  .s_rvalid_o(s_rvalid_o), .s_rready_i(s_rready_i), .s_rdata_o(s_rdata_o),
  .s_rresp_o(s_rresp_o), .fifo_v_o(fifo_v_o)
);

//--- bench/bridge_tb.sv
// drives the bridge through tx, rx, decode, rom and back-pressure cases
// every handshake wait gives up after TIMEOUT cycles and counts as an error
module bridge_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NS      = axil_fifo_pkg::NUM_SLOTS;
  localparam int ELS     = axil_fifo_pkg::FIFO_ELS;
  localparam int TIMEOUT = 100;

  logic clk_i, reset_i;
  logic [31:0] s_awaddr_i, s_wdata_i, s_araddr_i, s_rdata_o, rom_addr_o, rom_data_i;
  logic s_awvalid_i, s_awready_o, s_wvalid_i, s_wready_o, s_bvalid_o, s_bready_i;
  logic s_arvalid_i, s_arready_o, s_rvalid_o, s_rready_i;
  axil_fifo_pkg::resp_e s_bresp_o, s_rresp_o;
  logic [NS-1:0] fifo_v_o, fifo_rdy_i, fifo_v_i, fifo_rdy_o, drain_en;
  logic [NS-1:0][31:0] fifo_data_o, fifo_data_i;

  // reference model state
  logic [31:0] isr_m [NS];
  logic [31:0] exp_tx_q [NS][$];  // written, not yet drained
  logic [31:0] rx_m [NS][$];
  // pending comparisons
  string name_q[$], rname_q[$];
  logic [31:0] exp_q[$], act_q[$];
  axil_fifo_pkg::resp_e rexp_q[$], ract_q[$];
  int checks = 0;
  int errors = 0;

  clock_gen clk0 (.clk_o(clk_i), .reset_o(reset_i));
  axil_fifo_bridge dut0 (.*);

  function automatic logic [31:0] rom_value(input logic [31:0] a);
    return {a[15:0] ^ a[31:16], ~a[15:0]};
  endfunction

  assign rom_data_i = rom_value(rom_addr_o);  // rom model

  function automatic logic [31:0] slot_addr(input int s, input logic [11:0] ofs);
    return axil_fifo_pkg::BASE_ADDR + (s << 12) + ofs;
  endfunction

  function automatic logic [31:0] win_of(input logic [31:0] a);
    if (a < axil_fifo_pkg::BASE_ADDR) return 32'hFFFF_FFFF;
    return (a - axil_fifo_pkg::BASE_ADDR) >> 12;
  endfunction

  // expected read data and response for an address
  function automatic void ref_reg(input logic [31:0] a, output logic [31:0] d,
                                  output axil_fifo_pkg::resp_e r);
    logic [31:0] w;
    w = win_of(a);
    d = '0;
    r = axil_fifo_pkg::RESP_DECERR;
    if (w == NS) begin
      d = rom_value(a);
      r = axil_fifo_pkg::RESP_OKAY;
    end else if (w < NS) begin
      r = axil_fifo_pkg::RESP_OKAY;
      case (a[11:0])
        12'h000: d = isr_m[w];
        12'h00C: d = 32'(ELS - exp_tx_q[w].size());
        12'h01C: d = 32'(rx_m[w].size());
        12'h020: d = rx_m[w][0];
        12'h024: d = (rx_m[w].size() >= 4) ? 32'd16 : 32'd0;
        default: d = 32'hBEEF_DEAD;
      endcase
    end
  endfunction

  task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_resp(input string name, input axil_fifo_pkg::resp_e exp,
                            input axil_fifo_pkg::resp_e act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s expected %s actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic note_timeout(input string what);
    errors++;
    $display("timeout: no %s within %0d cycles", what, TIMEOUT);
  endtask

  // inputs change 1 ns after the rising edge
  task automatic wait_drive_time();
    @(posedge clk_i);
    #1;
  endtask

  // ---------------------------------------------------------------------
  // comparing process and fabric models
  // ---------------------------------------------------------------------
  always @(negedge clk_i) begin
    while (act_q.size() > 0) check_data(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
    while (ract_q.size() > 0)
      check_resp(rname_q.pop_front(), rexp_q.pop_front(), ract_q.pop_front());
  end

  // words leave on the next edge, values are stable here
  always @(negedge clk_i) begin
    for (int i = 0; i < NS; i++) begin
      if (!reset_i && fifo_v_o[i] && fifo_rdy_i[i]) begin
        if (exp_tx_q[i].size() == 0) begin
          errors++;
          $display("slot %0d sent a word that was never accepted", i);
        end else begin
          name_q.push_back("tx_order");
          exp_q.push_back(exp_tx_q[i].pop_front());
          act_q.push_back(fifo_data_o[i]);
        end
      end
    end
  end

  initial begin
    fifo_rdy_i = '0;
    forever begin
      @(posedge clk_i);
      #1;
      for (int i = 0; i < NS; i++) fifo_rdy_i[i] = drain_en[i] && ($urandom_range(3) != 0);
    end
  end

  // ---------------------------------------------------------------------
  // axi-lite host tasks
  // ---------------------------------------------------------------------
  task automatic axil_write(input logic [31:0] a, input logic [31:0] d, input int bstall,
                            output axil_fifo_pkg::resp_e r);
    int n;
    wait_drive_time();
    s_awaddr_i = a;
    s_awvalid_i = 1'b1;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!s_awready_o && n < TIMEOUT);
    if (!s_awready_o) note_timeout("awready");
    @(posedge clk_i);
    #1 s_awvalid_i = 1'b0;
    s_wdata_i = d;
    s_wvalid_i = 1'b1;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!s_wready_o && n < TIMEOUT);
    if (!s_wready_o) note_timeout("wready");
    @(posedge clk_i);
    #1 s_wvalid_i = 1'b0;
    if (bstall > 0) begin
      repeat (bstall) @(posedge clk_i);
      #1;
    end
    s_bready_i = 1'b1;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!s_bvalid_o && n < TIMEOUT);
    if (!s_bvalid_o) note_timeout("bvalid");
    r = s_bresp_o;
    @(posedge clk_i);
    #1 s_bready_i = 1'b0;
  endtask

  task automatic axil_read(input logic [31:0] a, input int rstall, output logic [31:0] d,
                           output axil_fifo_pkg::resp_e r);
    int n;
    wait_drive_time();
    s_araddr_i = a;
    s_arvalid_i = 1'b1;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!s_arready_o && n < TIMEOUT);
    if (!s_arready_o) note_timeout("arready");
    @(posedge clk_i);
    #1 s_arvalid_i = 1'b0;
    if (rstall > 0) begin
      repeat (rstall) @(posedge clk_i);
      #1;
    end
    s_rready_i = 1'b1;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!s_rvalid_o && n < TIMEOUT);
    if (!s_rvalid_o) note_timeout("rvalid");
    d = s_rdata_o;
    r = s_rresp_o;
    @(posedge clk_i);
    #1 s_rready_i = 1'b0;
  endtask

  // model update goes first, the fabric may drain before bvalid is seen
  task automatic write_check(input string name, input logic [31:0] a, input logic [31:0] d,
                             input int bstall);
    logic [31:0] w;
    axil_fifo_pkg::resp_e r;
    w = win_of(a);
    if (w < NS && a[11:0] == 12'h000) isr_m[w] = d;
    if (w < NS && a[11:0] == 12'h010 && exp_tx_q[w].size() < ELS) begin
      exp_tx_q[w].push_back(d);
      isr_m[w][27] = 1'b1;
    end
    axil_write(a, d, bstall, r);
    rname_q.push_back(name);
    rexp_q.push_back((w < NS) ? axil_fifo_pkg::RESP_OKAY : axil_fifo_pkg::RESP_DECERR);
    ract_q.push_back(r);
  endtask

  task automatic read_check(input string name, input logic [31:0] a, input int rstall);
    logic [31:0] ed, d;
    axil_fifo_pkg::resp_e er, r;
    ref_reg(a, ed, er);
    axil_read(a, rstall, d, r);
    rname_q.push_back(name);
    rexp_q.push_back(er);
    ract_q.push_back(r);
    if (er == axil_fifo_pkg::RESP_OKAY) begin
      name_q.push_back(name);
      exp_q.push_back(ed);
      act_q.push_back(d);
    end
    if (win_of(a) < NS && a[11:0] == 12'h020) void'(rx_m[win_of(a)].pop_front());
  endtask

  task automatic rx_push(input int s, input logic [31:0] d);
    int n;
    wait_drive_time();
    fifo_v_i[s] = 1'b1;
    fifo_data_i[s] = d;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!fifo_rdy_o[s] && n < TIMEOUT);
    if (!fifo_rdy_o[s]) note_timeout("fifo_rdy_o");
    @(posedge clk_i);
    #1 fifo_v_i[s] = 1'b0;
    rx_m[s].push_back(d);
  endtask

  task automatic wait_drained(input int s);
    int n;
    n = 0;
    while (exp_tx_q[s].size() > 0 && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (exp_tx_q[s].size() > 0) note_timeout("drain of the transmit fifo");
  endtask

  task automatic ready_check(input int s);
    @(negedge clk_i);
    name_q.push_back("rx_ready");
    exp_q.push_back(32'(rx_m[s].size() < ELS));
    act_q.push_back(32'(fifo_rdy_o[s]));
  endtask

  task automatic report_test(input string name, input int errs_before);
    repeat (3) @(negedge clk_i);  // let the compare process catch up
    $display("test %s: %s", name, (errors == errs_before) ? "ok" : "mismatches");
  endtask

  // ---------------------------------------------------------------------
  // tests
  // ---------------------------------------------------------------------
  initial begin
    int e, n;
    {s_awaddr_i, s_wdata_i, s_araddr_i} = '0;
    {s_awvalid_i, s_wvalid_i, s_bready_i, s_arvalid_i, s_rready_i} = '0;
    fifo_v_i = '0;
    fifo_data_i = '0;
    drain_en = '1;
    for (int i = 0; i < NS; i++) isr_m[i] = '0;
    void'($urandom(32'hb50c));
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (reset_i && n < TIMEOUT);
    if (reset_i) note_timeout("reset release");

    e = errors;
    for (int s = 0; s < NS; s++) begin
      write_check("isr_clear", slot_addr(s, 12'h000), 32'h0, 0);
      for (int k = 0; k < 5; k++) write_check("tdr_write", slot_addr(s, 12'h010), $urandom, 0);
      wait_drained(s);
      read_check("isr_tx_done", slot_addr(s, 12'h000), 0);
    end
    report_test("tx_order", e);

    e = errors;
    drain_en[1] = 1'b0;
    for (int k = 0; k < ELS; k++) begin
      write_check("tdr_fill", slot_addr(1, 12'h010), $urandom, 0);
      read_check("tdfv", slot_addr(1, 12'h00C), 0);
    end
    write_check("isr_clear", slot_addr(1, 12'h000), 32'h0, 0);
    write_check("tdr_overflow", slot_addr(1, 12'h010), $urandom, 0);  // dropped by the model
    read_check("isr_after_drop", slot_addr(1, 12'h000), 0);
    drain_en[1] = 1'b1;
    wait_drained(1);
    repeat (10) @(negedge clk_i);  // an extra word would surface here
    read_check("tdfv_empty", slot_addr(1, 12'h00C), 0);
    report_test("tx_overflow", e);

    e = errors;
    for (int k = 0; k < ELS; k++) begin
      ready_check(0);
      rx_push(0, $urandom);
      read_check("rdfo_fill", slot_addr(0, 12'h01C), 0);
    end
    ready_check(0);  // full now
    for (int k = 0; k < ELS; k++) begin
      read_check("rdfo", slot_addr(0, 12'h01C), 0);
      read_check("rlr", slot_addr(0, 12'h024), 0);
      read_check("rdr", slot_addr(0, 12'h020), 0);
    end
    read_check("rdfo_empty", slot_addr(0, 12'h01C), 0);
    report_test("rx_path", e);

    e = errors;
    read_check("rd_below_base", axil_fifo_pkg::BASE_ADDR - 4, 0);
    write_check("wr_below_base", axil_fifo_pkg::BASE_ADDR - 4, 32'h1, 0);
    read_check("rd_above_rom", slot_addr(NS + 1, 12'h010), 0);
    write_check("wr_above_rom", slot_addr(NS + 1, 12'h000), 32'h2, 0);
    write_check("wr_rom", slot_addr(NS, 12'h000), 32'h3, 0);
    read_check("unmapped_ofs", slot_addr(0, 12'h008), 0);
    read_check("unmapped_ofs_high", slot_addr(1, 12'hFF0), 0);
    report_test("decode", e);

    e = errors;
    read_check("rom_0", slot_addr(NS, 12'h000), 0);
    read_check("rom_4", slot_addr(NS, 12'h004), 0);
    read_check("rom_100", slot_addr(NS, 12'h100), 0);
    read_check("rom_ffc", slot_addr(NS, 12'hFFC), 0);
    report_test("rom", e);

    e = errors;
    for (int k = 0; k < 3; k++) rx_push(1, $urandom);
    for (int k = 0; k < 6; k++) begin
      write_check("isr_stall", slot_addr(k % NS, 12'h000), $urandom, $urandom_range(7));
      read_check("isr_stall", slot_addr(k % NS, 12'h000), $urandom_range(7));
    end
    for (int k = 0; k < 3; k++) read_check("rdr_stall", slot_addr(1, 12'h020), $urandom_range(7));
    read_check("rom_stall", slot_addr(NS, 12'h040), $urandom_range(7));
    report_test("backpressure", e);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- verilog.f
logic/axil_fifo_pkg.sv
logic/fifo_small.sv
logic/axil_write_ctrl.sv
logic/axil_read_ctrl.sv
logic/axil_fifo_bridge.sv
bench/clock_gen.sv
bench/bridge_chk.sv
bench/bridge_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= bridge_tb
FILELIST  ?= verilog.f
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
